/* src/scope_config.svh */
// scope core build constants
`ifndef SCOPE_CONFIG_SVH
`define SCOPE_CONFIG_SVH

// ----------------------------------------------------------------------
// command framing
// ----------------------------------------------------------------------
`define SCOPE_CMD_BYTES 8	// fixed command length in bytes

// ----------------------------------------------------------------------
// acquisition
// ----------------------------------------------------------------------
`define SCOPE_SAMPLE_W 12	// adc sample width
`define SCOPE_FIFO_AW 6	// 64 sample deep fifo
`define SCOPE_VERSION 5	// firmware version word
`define SCOPE_THRESH_LO (-10)	// trigger arms below this
`define SCOPE_THRESH_HI 10	// trigger fires above this

`endif

/* src/scope_cmd_pkg.sv */
// command path types

package scope_cmd_pkg;

	typedef logic [7:0] cmd_byte_t;	// one byte of the host command
	typedef logic [15:0] byte_len_t;	// reply or capture length

	// opcode carried in command byte 0
	typedef enum cmd_byte_t {
		OP_READOUT = 8'd0,	// stream captured samples
		OP_CLKSW = 8'd1,	// toggle clock source
		OP_VERSION = 8'd2,	// firmware version
		OP_ARM = 8'd5	// set trigger and length, start capture
	} opcode_e;

	// host controller FSM
	typedef enum logic [2:0] {
		CTRL_IDLE,	// waiting for a command
		CTRL_DECODE,	// act on opcode
		CTRL_POP_LO,	// older sample of a readout word
		CTRL_POP_HI,	// newer sample, word goes out
		CTRL_SEND	// hold beat until accepted
	} ctrl_state_e;

endpackage

/* src/scope_acq_pkg.sv */
// acquisition and reply stream types
`include "scope_config.svh"

package scope_acq_pkg;

	typedef logic signed [`SCOPE_SAMPLE_W-1:0] sample_t;	// two's complement adc sample
	typedef logic [31:0] word_t;	// reply stream word
	typedef logic [3:0] keep_t;	// one flag per reply byte
	typedef logic [7:0] trig_type_t;	// 1 = threshold, else immediate

	// capture FSM
	typedef enum logic [1:0] {
		ACQ_IDLE,	// ready for an arm
		ACQ_WAIT_LOW,	// waiting for sample below low threshold
		ACQ_WAIT_HIGH,	// then for sample above high threshold
		ACQ_CAPTURE	// one sample into the fifo per clock
	} acq_state_e;

endpackage

/* src/cmd_receiver.sv */
// host command byte collector
`include "scope_config.svh"

module cmd_receiver (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            i_s_valid,
	input  scope_cmd_pkg::cmd_byte_t        i_s_data,
	output logic                            o_s_ready,
	output logic                            o_cmd_valid,
	output logic [`SCOPE_CMD_BYTES*8-1:0]   o_cmd_bytes,
	input  logic                            i_cmd_done
);
	import scope_cmd_pkg::*;

	localparam int CW = $clog2(`SCOPE_CMD_BYTES);
	localparam logic [CW-1:0] LAST_IDX = CW'(`SCOPE_CMD_BYTES - 1);

	cmd_byte_t rx_bytes [`SCOPE_CMD_BYTES];
	logic [CW-1:0] rx_cnt;	// next byte slot
	logic take;

	assign take = i_s_valid && o_s_ready;

	always_ff @(posedge clk) begin
		if (take)
			rx_bytes[rx_cnt] <= i_s_data;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			rx_cnt <= '0;
			o_s_ready <= 1'b1;
			o_cmd_valid <= 1'b0;
		end else begin
			o_cmd_valid <= 1'b0;	// single cycle pulse
			if (take) begin
				if (rx_cnt == LAST_IDX) begin
					rx_cnt <= '0;
					o_s_ready <= 1'b0;	// stall until the command is done
					o_cmd_valid <= 1'b1;
				end else begin
					rx_cnt <= rx_cnt + 1'b1;
				end
			end else if (i_cmd_done) begin
				o_s_ready <= 1'b1;
			end
		end
	end

	// byte k lands at bits 8k+7:8k
	always_comb begin
		for (int i = 0; i < `SCOPE_CMD_BYTES; i++)
			o_cmd_bytes[i*8 +: 8] = rx_bytes[i];
	end

endmodule

/* src/acq_trigger.sv */
// acquisition arming, trigger and capture
`include "scope_config.svh"

module acq_trigger (
	input  logic                        clk,
	input  logic                        rstn,
	input  logic                        i_arm,
	input  scope_acq_pkg::trig_type_t   i_trig_type,
	input  scope_cmd_pkg::byte_len_t    i_take_len,
	input  scope_acq_pkg::sample_t      i_sample,
	input  logic                        i_fifo_full,
	output logic                        o_fifo_wr,
	output scope_acq_pkg::sample_t      o_fifo_data,
	output logic                        o_idle
);
	import scope_acq_pkg::*;
	import scope_cmd_pkg::*;

	localparam sample_t THRESH_LO = sample_t'(`SCOPE_THRESH_LO);
	localparam sample_t THRESH_HI = sample_t'(`SCOPE_THRESH_HI);
	localparam trig_type_t TRIG_THRESH = 8'd1;

	acq_state_e state;
	sample_t sample_q;	// registered input, feeds compare and fifo
	byte_len_t take_len;
	byte_len_t taken;	// samples written so far
	logic wr_en;

	always_ff @(posedge clk) begin
		sample_q <= i_sample;
	end

	assign wr_en = (state == ACQ_CAPTURE) && !i_fifo_full && (taken < take_len);
	assign o_fifo_wr = wr_en;
	assign o_fifo_data = sample_q;
	assign o_idle = (state == ACQ_IDLE);

	// ----------------------------------------------------------------------
	// capture FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= ACQ_IDLE;
			take_len <= '0;
			taken <= '0;
		end else begin
			case (state)
				ACQ_IDLE: if (i_arm) begin
					take_len <= i_take_len;
					taken <= '0;
					state <= (i_trig_type == TRIG_THRESH) ? ACQ_WAIT_LOW : ACQ_CAPTURE;
				end
				ACQ_WAIT_LOW: if (sample_q < THRESH_LO) state <= ACQ_WAIT_HIGH;
				ACQ_WAIT_HIGH: if (sample_q > THRESH_HI) state <= ACQ_CAPTURE;
				ACQ_CAPTURE: begin
					if (!wr_en) begin
						state <= ACQ_IDLE;	// fifo full or nothing requested
					end else begin
						taken <= taken + 1'b1;
						if (taken + 1'b1 == take_len)
							state <= ACQ_IDLE;
					end
				end
				default: state <= ACQ_IDLE;
			endcase
		end
	end

endmodule

/* src/sample_fifo.sv */
// synchronous sample fifo
`include "scope_config.svh"

module sample_fifo #(
	parameter int AW = `SCOPE_FIFO_AW
) (
	input  logic                    clk,
	input  logic                    rstn,
	input  logic                    i_wr,
	input  scope_acq_pkg::sample_t  i_wr_data,
	input  logic                    i_rd,
	output scope_acq_pkg::sample_t  o_rd_data,
	output logic                    o_full,
	output logic [AW:0]             o_level
);
	import scope_acq_pkg::*;

	localparam logic [AW:0] DEPTH = {1'b1, {AW{1'b0}}};

	sample_t mem [0:(1<<AW)-1];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign do_wr = i_wr && !o_full;	// writes to a full fifo are lost
	assign do_rd = i_rd && (o_level != '0);
	assign o_full = (o_level == DEPTH);
	assign o_rd_data = mem[rd_ptr];	// head entry, no read latency

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= i_wr_data;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			o_level <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: o_level <= o_level + 1'b1;
				2'b01: o_level <= o_level - 1'b1;
				default: o_level <= o_level;	// both or neither
			endcase
		end
	end

endmodule

/* src/host_controller.sv */
// host command decode and reply stream
`include "scope_config.svh"

module host_controller (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            i_cmd_valid,
	input  logic [`SCOPE_CMD_BYTES*8-1:0]   i_cmd_bytes,
	output logic                            o_cmd_done,
	input  logic                            i_acq_idle,
	output logic                            o_arm,
	output scope_acq_pkg::trig_type_t       o_trig_type,
	output scope_cmd_pkg::byte_len_t        o_take_len,
	output logic                            o_fifo_rd,
	input  scope_acq_pkg::sample_t          i_fifo_data,
	input  logic [`SCOPE_FIFO_AW:0]         i_fifo_level,
	input  logic                            i_active_clock,
	input  logic [1:0]                      i_clk_bad,
	output logic                            o_clk_switch,
	input  logic                            i_m_ready,
	output logic                            o_m_valid,
	output scope_acq_pkg::word_t            o_m_data,
	output scope_acq_pkg::keep_t            o_m_keep,
	output logic                            o_m_last
);
	import scope_cmd_pkg::*;
	import scope_acq_pkg::*;

	localparam byte_len_t WORD_BYTES = 16'd4;
	localparam int PAD_W = 16 - `SCOPE_SAMPLE_W;	// zero fill above each sample

	ctrl_state_e state;
	cmd_byte_t cmd_b [`SCOPE_CMD_BYTES];
	opcode_e opcode;
	byte_len_t req_len;
	byte_len_t rem;	// reply bytes still to send, this beat included
	sample_t hold_lo;	// older sample of the word being built
	logic pair_ready;

	always_comb begin
		for (int i = 0; i < `SCOPE_CMD_BYTES; i++)
			cmd_b[i] = i_cmd_bytes[i*8 +: 8];
	end

	assign opcode = opcode_e'(cmd_b[0]);
	assign req_len = {cmd_b[5], cmd_b[4]};
	assign pair_ready = (i_fifo_level >= 2);
	assign o_fifo_rd = ((state == CTRL_POP_LO) && pair_ready) || (state == CTRL_POP_HI);

	// keep flags for a beat with left bytes outstanding
	function automatic keep_t beat_keep(input byte_len_t left);
		keep_t k;
		case (left)
			16'd1: k = 4'b0001;
			16'd2: k = 4'b0011;
			16'd3: k = 4'b0111;
			default: k = 4'b1111;
		endcase
		return k;
	endfunction

	// ----------------------------------------------------------------------
	// control FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= CTRL_IDLE;
			rem <= '0;
			o_m_valid <= 1'b0;
			o_cmd_done <= 1'b0;
			o_arm <= 1'b0;
			o_clk_switch <= 1'b0;
		end else begin
			o_cmd_done <= 1'b0;
			o_arm <= 1'b0;
			case (state)
				CTRL_IDLE: if (i_cmd_valid) state <= CTRL_DECODE;
				CTRL_DECODE: begin
					case (opcode)
						OP_VERSION: begin
							rem <= WORD_BYTES;
							o_m_valid <= 1'b1;
							state <= CTRL_SEND;
						end
						OP_CLKSW: begin
							o_clk_switch <= ~o_clk_switch;
							rem <= WORD_BYTES;
							o_m_valid <= 1'b1;
							state <= CTRL_SEND;
						end
						OP_READOUT: begin
							rem <= req_len;
							if (req_len == '0) begin
								o_cmd_done <= 1'b1;	// nothing to send
								state <= CTRL_IDLE;
							end else begin
								state <= CTRL_POP_LO;
							end
						end
						OP_ARM: begin
							o_arm <= i_acq_idle;	// dropped while capture runs
							o_cmd_done <= 1'b1;
							state <= CTRL_IDLE;
						end
						default: begin
							o_cmd_done <= 1'b1;	// unknown opcode
							state <= CTRL_IDLE;
						end
					endcase
				end
				CTRL_POP_LO: if (pair_ready) state <= CTRL_POP_HI;
				CTRL_POP_HI: begin
					o_m_valid <= 1'b1;
					state <= CTRL_SEND;
				end
				CTRL_SEND: if (i_m_ready) begin
					o_m_valid <= 1'b0;
					if (rem <= WORD_BYTES) begin
						o_cmd_done <= 1'b1;
						state <= CTRL_IDLE;
					end else begin
						rem <= rem - WORD_BYTES;
						state <= CTRL_POP_LO;
					end
				end
				default: state <= CTRL_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// reply word, keep and last, arm parameters
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		case (state)
			CTRL_DECODE: begin
				o_trig_type <= cmd_b[1];
				o_take_len <= req_len;
				o_m_keep <= beat_keep(WORD_BYTES);
				o_m_last <= 1'b1;
				if (opcode == OP_CLKSW)
					o_m_data <= {7'd0, i_clk_bad[1], 7'd0, i_clk_bad[0],
						7'd0, i_active_clock, 7'd0, o_clk_switch};	// select before toggle
				else
					o_m_data <= word_t'(`SCOPE_VERSION);
			end
			CTRL_POP_LO: if (pair_ready) hold_lo <= i_fifo_data;
			CTRL_POP_HI: begin
				o_m_data <= {{PAD_W{1'b0}}, i_fifo_data, {PAD_W{1'b0}}, hold_lo};
				o_m_keep <= beat_keep(rem);
				o_m_last <= (rem <= WORD_BYTES);
			end
			default: ;
		endcase
	end

endmodule

/* src/scope_top.sv */
// digitizer host command core
`include "scope_config.svh"

module scope_top (
	input  logic                        clk,
	input  logic                        rstn,
	input  logic                        i_s_valid,
	input  scope_cmd_pkg::cmd_byte_t    i_s_data,
	output logic                        o_s_ready,
	input  logic                        i_m_ready,
	output logic                        o_m_valid,
	output scope_acq_pkg::word_t        o_m_data,
	output scope_acq_pkg::keep_t        o_m_keep,
	output logic                        o_m_last,
	input  scope_acq_pkg::sample_t      i_sample,
	input  logic                        i_active_clock,
	input  logic [1:0]                  i_clk_bad,
	output logic                        o_clk_switch
);
	import scope_cmd_pkg::*;
	import scope_acq_pkg::*;

	logic cmd_valid, cmd_done;
	logic [`SCOPE_CMD_BYTES*8-1:0] cmd_bytes;
	logic arm, acq_idle;
	trig_type_t trig_type;
	byte_len_t take_len;
	logic fifo_wr, fifo_rd, fifo_full;
	sample_t fifo_wr_data, fifo_rd_data;
	logic [`SCOPE_FIFO_AW:0] fifo_level;

	cmd_receiver u_cmd_receiver (.clk, .rstn, .i_s_valid, .i_s_data, .o_s_ready,
		.o_cmd_valid(cmd_valid), .o_cmd_bytes(cmd_bytes), .i_cmd_done(cmd_done));

	acq_trigger u_acq_trigger (.clk, .rstn, .i_arm(arm), .i_trig_type(trig_type),
		.i_take_len(take_len), .i_sample, .i_fifo_full(fifo_full), .o_fifo_wr(fifo_wr),
		.o_fifo_data(fifo_wr_data), .o_idle(acq_idle));

	sample_fifo #(.AW(`SCOPE_FIFO_AW)) u_sample_fifo (.clk, .rstn, .i_wr(fifo_wr),
		.i_wr_data(fifo_wr_data), .i_rd(fifo_rd), .o_rd_data(fifo_rd_data),
		.o_full(fifo_full), .o_level(fifo_level));

	host_controller u_host_controller (.clk, .rstn, .i_cmd_valid(cmd_valid),
		.i_cmd_bytes(cmd_bytes), .o_cmd_done(cmd_done), .i_acq_idle(acq_idle),
		.o_arm(arm), .o_trig_type(trig_type), .o_take_len(take_len), .o_fifo_rd(fifo_rd),
		.i_fifo_data(fifo_rd_data), .i_fifo_level(fifo_level), .i_active_clock,
		.i_clk_bad, .o_clk_switch, .i_m_ready, .o_m_valid, .o_m_data, .o_m_keep, .o_m_last);

endmodule

/* tb/scope_top_assert.sv */
// reply stream protocol checks
module scope_top_assert (
	input logic                  clk,
	input logic                  rstn,
	input logic                  i_m_ready,
	input logic                  o_m_valid,
	input scope_acq_pkg::word_t  o_m_data,
	input scope_acq_pkg::keep_t  o_m_keep,
	input logic                  o_m_last,
	input logic                  o_s_ready
);
	timeunit 1ns;
	timeprecision 100ps;

	int err_cnt = 0;	// failed assertions so far

	// a stalled beat keeps its payload until it is taken
	a_hold: assert property (@(posedge clk) disable iff (!rstn)
		(o_m_valid && !i_m_ready) |=> (o_m_valid && $stable(o_m_data)
			&& $stable(o_m_keep) && $stable(o_m_last)))
	else begin
		err_cnt++;
		$error("reply beat changed while stalled");
	end

	a_keep: assert property (@(posedge clk) disable iff (!rstn)
		o_m_valid |-> (o_m_keep != '0))
	else begin
		err_cnt++;
		$error("reply beat with no keep flag set");
	end

	a_excl: assert property (@(posedge clk) disable iff (!rstn)
		o_m_valid |-> !o_s_ready)
	else begin
		err_cnt++;
		$error("command input ready during a reply");
	end

endmodule

/* tb/tb_scope_top.sv */
// scope core table testbench
`include "scope_config.svh"

module tb_scope_top;
	timeunit 1ns;
	timeprecision 100ps;
	import scope_acq_pkg::*;

	localparam int NUM_ROWS = 11;
	localparam int RST_CYCLES = 10;
	localparam int SEED = 97103;
	localparam logic ACTIVE_CLK = 1'b1;
	localparam logic [1:0] CLK_BAD = 2'b10;
	localparam logic [1:0] CHK_NONE = 2'd0;
	localparam logic [1:0] CHK_WORDS = 2'd1;	// compare with w0 and w1
	localparam logic [1:0] CHK_RAMP_NEW = 2'd2;	// sample model from a fresh start
	localparam logic [1:0] CHK_RAMP_CONT = 2'd3;	// sample model carrying on

	typedef struct packed {
		logic [63:0] cmd;	// byte k at 8k+7:8k
		logic [15:0] len;	// expected reply bytes
		logic [1:0] chk;
		logic pattern;	// start trigger pattern when done
		logic [1:0] sel;	// clock select afterwards or 2 for don't care
		logic [31:0] w0;
		logic [31:0] w1;
	} row_t;

	logic clk, rstn, i_s_valid, o_s_ready, i_m_ready, o_m_valid, o_m_last;
	logic [7:0] i_s_data;
	word_t o_m_data;
	keep_t o_m_keep;
	sample_t i_sample;
	logic i_active_clock, o_clk_switch;
	logic [1:0] i_clk_bad;

	row_t rows [NUM_ROWS];
	int ramp_val;
	int pat_step;
	logic pat_on;
	logic [11:0] ramp_next;	// next sample the model expects

	scope_top i_scope_top (.clk, .rstn, .i_s_valid, .i_s_data, .o_s_ready, .i_m_ready,
		.o_m_valid, .o_m_data, .o_m_keep, .o_m_last, .i_sample, .i_active_clock,
		.i_clk_bad, .o_clk_switch);

	bind scope_top scope_top_assert u_stream_assert (.clk, .rstn, .i_m_ready, .o_m_valid,
		.o_m_data, .o_m_keep, .o_m_last, .o_s_ready);

	function automatic logic [63:0] make_cmd(input logic [7:0] op, input logic [7:0] trig,
		input logic [15:0] len);
		return {16'h0000, len, 16'h0000, trig, op};
	endfunction

	// each status flag in bit 0 of its own byte
	function automatic logic [31:0] clk_reply(input logic sel_before);
		logic [31:0] w;
		w = '0;
		w[0] = sel_before;
		w[8] = ACTIVE_CLK;
		w[16] = CLK_BAD[0];
		w[24] = CLK_BAD[1];
		return w;
	endfunction

	function automatic logic [3:0] exp_keep(input int left);
		if (left >= 4)
			return 4'b1111;
		return 4'((1 << left) - 1);
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic send_cmd(input logic [63:0] cmd);
		for (int k = 0; k < `SCOPE_CMD_BYTES; k++) begin
			@(negedge clk);
			while (!o_s_ready)
				@(negedge clk);
			i_s_valid = 1'b1;
			i_s_data = cmd[k*8 +: 8];
		end
		@(negedge clk);
		i_s_valid = 1'b0;
	endtask

	task automatic check_word(input row_t r, input int idx, input logic [31:0] data);
		logic [11:0] lo;
		logic [11:0] hi;
		logic [11:0] lo_inc;
		lo = data[11:0];
		hi = data[27:16];
		lo_inc = lo + 12'd1;
		if (r.chk == CHK_WORDS) begin
			check_value("reply word", data, (idx == 0) ? r.w0 : r.w1);
		end else begin
			check_value("unused bits", {data[31:28], data[15:12]}, 32'd0);
			if (!(r.chk == CHK_RAMP_NEW && idx == 0))
				check_value("older sample", lo, ramp_next);
			check_value("newer sample", hi, lo_inc);
			ramp_next = hi + 12'd1;
		end
	endtask

	// beats are recorded on the falling edge before the accepting edge
	task automatic collect_reply(input row_t r);
		int left;
		int beat;
		left = r.len;
		beat = 0;
		while (left > 0) begin
			@(negedge clk);
			i_m_ready = (($urandom % 10) < 7);	// about 70% ready
			if (o_m_valid && i_m_ready) begin
				check_value("keep", o_m_keep, exp_keep(left));
				check_value("last", o_m_last, left <= 4);
				check_word(r, beat, o_m_data);
				left -= 4;
				beat++;
			end
		end
		@(negedge clk);
		i_m_ready = 1'b0;
		check_value("valid after last beat", o_m_valid, 1'b0);
		@(negedge clk);
		check_value("ready after reply", o_s_ready, 1'b1);
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ramp until the trigger pattern starts
	always @(negedge clk) begin
		if (pat_on) begin
			if (pat_step < 6)
				i_sample = '0;
			else if (pat_step < 12)
				i_sample = sample_t'(-20);	// below the low threshold
			else
				i_sample = sample_t'(50 + pat_step - 12);
			pat_step++;
		end else begin
			i_sample = sample_t'(ramp_val);
			ramp_val++;
		end
	end

	always @(negedge clk) begin
		if (i_scope_top.u_stream_assert.err_cnt != 0) begin
			$display("a bound stream assertion failed by t=%0t", $time);
			$display("CHECKS FAILED");
			$fatal(1, "assertion failure");
		end
	end

	initial begin
		repeat (RST_CYCLES + NUM_ROWS * 2000) @(posedge clk);
		$display("watchdog expired before all table rows completed");
		$display("CHECKS FAILED");
		$fatal(1, "timeout");
	end

	// ----------------------------------------------------------------------
	// stimulus table and main loop
	// ----------------------------------------------------------------------
	initial begin
		void'($urandom(SEED));
		rstn = 1'b0;
		i_s_valid = 1'b0;
		i_s_data = '0;
		i_m_ready = 1'b0;
		i_sample = '0;
		i_active_clock = ACTIVE_CLK;
		i_clk_bad = CLK_BAD;
		ramp_val = 0;
		pat_step = 0;
		pat_on = 1'b0;
		ramp_next = '0;
		rows[0] = '{make_cmd(8'd2, 8'd0, 16'd0), 16'd4, CHK_WORDS, 1'b0, 2'd2,
			32'(`SCOPE_VERSION), 32'd0};
		rows[1] = '{make_cmd(8'd1, 8'd0, 16'd0), 16'd4, CHK_WORDS, 1'b0, 2'd1,
			clk_reply(1'b0), 32'd0};
		rows[2] = '{make_cmd(8'd1, 8'd0, 16'd0), 16'd4, CHK_WORDS, 1'b0, 2'd0,
			clk_reply(1'b1), 32'd0};
		rows[3] = '{make_cmd(8'd5, 8'd0, 16'd8), 16'd0, CHK_NONE, 1'b0, 2'd2, 32'd0, 32'd0};
		rows[4] = '{make_cmd(8'd0, 8'd0, 16'd16), 16'd16, CHK_RAMP_NEW, 1'b0, 2'd2,
			32'd0, 32'd0};
		rows[5] = '{make_cmd(8'd5, 8'd1, 16'd4), 16'd0, CHK_NONE, 1'b1, 2'd2, 32'd0, 32'd0};
		// capture starts one sample after the 50 that fired
		rows[6] = '{make_cmd(8'd0, 8'd0, 16'd8), 16'd8, CHK_WORDS, 1'b0, 2'd2,
			{16'd52, 16'd51}, {16'd54, 16'd53}};
		rows[7] = '{make_cmd(8'd5, 8'd0, 16'd40), 16'd0, CHK_NONE, 1'b0, 2'd2, 32'd0, 32'd0};
		rows[8] = '{make_cmd(8'd5, 8'd0, 16'd2), 16'd0, CHK_NONE, 1'b0, 2'd2, 32'd0, 32'd0};
		rows[9] = '{make_cmd(8'd0, 8'd0, 16'd6), 16'd6, CHK_RAMP_NEW, 1'b0, 2'd2,
			32'd0, 32'd0};
		rows[10] = '{make_cmd(8'd0, 8'd0, 16'd72), 16'd72, CHK_RAMP_CONT, 1'b0, 2'd2,
			32'd0, 32'd0};	// rest of the 40 samples

		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		check_value("ready after reset", o_s_ready, 1'b1);
		check_value("valid after reset", o_m_valid, 1'b0);
		check_value("clock select after reset", o_clk_switch, 1'b0);

		for (int n = 0; n < NUM_ROWS; n++) begin
			send_cmd(rows[n].cmd);
			if (rows[n].len == 0) begin
				while (!o_s_ready)
					@(negedge clk);	// no reply so wait for done
			end else begin
				collect_reply(rows[n]);
			end
			if (rows[n].sel != 2'd2)
				check_value("clock select", o_clk_switch, rows[n].sel);
			if (rows[n].pattern)
				pat_on = 1'b1;
		end

		if (i_scope_top.u_stream_assert.err_cnt == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("CHECKS FAILED");
			$fatal(1, "errors recorded");
		end
	end

endmodule

/* vlog.f */
+incdir+src
src/scope_cmd_pkg.sv
src/scope_acq_pkg.sv
src/cmd_receiver.sv
src/acq_trigger.sv
src/sample_fifo.sv
src/host_controller.sv
src/scope_top.sv
tb/scope_top_assert.sv
tb/tb_scope_top.sv
